// File: verilog/AesDecPkg.sv
`default_nettype none

package AesDecPkg;

	typedef logic [7:0]   byteT;     // one state byte
	typedef logic [31:0]  wordT;     // bus word or state column
	typedef logic [127:0] blockT;    // byte 0 sits in bits 127:120
	typedef logic [3:0]   roundIdxT; // round key index 0..10
	typedef logic [5:0]   wbAdrT;    // word address

	typedef enum logic {
		SeqIdle,
		SeqRound
	} seqStateT;

	localparam int NumRounds = 10;

	// word addresses on the bus
	localparam wbAdrT AdrKeyBase = 6'd0;  // key r word w at 4*r+w
	localparam wbAdrT AdrDataIn  = 6'd44; // ciphertext words 44..47
	localparam wbAdrT AdrCtrl    = 6'd48; // bit 0 starts
	localparam wbAdrT AdrStatus  = 6'd49; // bit 0 busy, bit 1 done
	localparam wbAdrT AdrDataOut = 6'd50; // plaintext words 50..53

endpackage

`default_nettype wire

// File: verilog/InvSBoxLookup.sv
`timescale 1ns/1ns
`default_nettype none

module InvSBoxLookup import AesDecPkg::*; (
	input  wire byteT in,
	output byteT      out
);

	// inverse substitution table, one row of 16 every four lines
	always_comb begin
		case (in)
		8'h00: out = 8'h52; 8'h01: out = 8'h09; 8'h02: out = 8'h6a; 8'h03: out = 8'hd5;
		8'h04: out = 8'h30; 8'h05: out = 8'h36; 8'h06: out = 8'ha5; 8'h07: out = 8'h38;
		8'h08: out = 8'hbf; 8'h09: out = 8'h40; 8'h0a: out = 8'ha3; 8'h0b: out = 8'h9e;
		8'h0c: out = 8'h81; 8'h0d: out = 8'hf3; 8'h0e: out = 8'hd7; 8'h0f: out = 8'hfb;
		8'h10: out = 8'h7c; 8'h11: out = 8'he3; 8'h12: out = 8'h39; 8'h13: out = 8'h82;
		8'h14: out = 8'h9b; 8'h15: out = 8'h2f; 8'h16: out = 8'hff; 8'h17: out = 8'h87;
		8'h18: out = 8'h34; 8'h19: out = 8'h8e; 8'h1a: out = 8'h43; 8'h1b: out = 8'h44;
		8'h1c: out = 8'hc4; 8'h1d: out = 8'hde; 8'h1e: out = 8'he9; 8'h1f: out = 8'hcb;
		8'h20: out = 8'h54; 8'h21: out = 8'h7b; 8'h22: out = 8'h94; 8'h23: out = 8'h32;
		8'h24: out = 8'ha6; 8'h25: out = 8'hc2; 8'h26: out = 8'h23; 8'h27: out = 8'h3d;
		8'h28: out = 8'hee; 8'h29: out = 8'h4c; 8'h2a: out = 8'h95; 8'h2b: out = 8'h0b;
		8'h2c: out = 8'h42; 8'h2d: out = 8'hfa; 8'h2e: out = 8'hc3; 8'h2f: out = 8'h4e;
		8'h30: out = 8'h08; 8'h31: out = 8'h2e; 8'h32: out = 8'ha1; 8'h33: out = 8'h66;
		8'h34: out = 8'h28; 8'h35: out = 8'hd9; 8'h36: out = 8'h24; 8'h37: out = 8'hb2;
		8'h38: out = 8'h76; 8'h39: out = 8'h5b; 8'h3a: out = 8'ha2; 8'h3b: out = 8'h49;
		8'h3c: out = 8'h6d; 8'h3d: out = 8'h8b; 8'h3e: out = 8'hd1; 8'h3f: out = 8'h25;
		8'h40: out = 8'h72; 8'h41: out = 8'hf8; 8'h42: out = 8'hf6; 8'h43: out = 8'h64;
		8'h44: out = 8'h86; 8'h45: out = 8'h68; 8'h46: out = 8'h98; 8'h47: out = 8'h16;
		8'h48: out = 8'hd4; 8'h49: out = 8'ha4; 8'h4a: out = 8'h5c; 8'h4b: out = 8'hcc;
		8'h4c: out = 8'h5d; 8'h4d: out = 8'h65; 8'h4e: out = 8'hb6; 8'h4f: out = 8'h92;
		8'h50: out = 8'h6c; 8'h51: out = 8'h70; 8'h52: out = 8'h48; 8'h53: out = 8'h50;
		8'h54: out = 8'hfd; 8'h55: out = 8'hed; 8'h56: out = 8'hb9; 8'h57: out = 8'hda;
		8'h58: out = 8'h5e; 8'h59: out = 8'h15; 8'h5a: out = 8'h46; 8'h5b: out = 8'h57;
		8'h5c: out = 8'ha7; 8'h5d: out = 8'h8d; 8'h5e: out = 8'h9d; 8'h5f: out = 8'h84;
		8'h60: out = 8'h90; 8'h61: out = 8'hd8; 8'h62: out = 8'hab; 8'h63: out = 8'h00;
		8'h64: out = 8'h8c; 8'h65: out = 8'hbc; 8'h66: out = 8'hd3; 8'h67: out = 8'h0a;
		8'h68: out = 8'hf7; 8'h69: out = 8'he4; 8'h6a: out = 8'h58; 8'h6b: out = 8'h05;
		8'h6c: out = 8'hb8; 8'h6d: out = 8'hb3; 8'h6e: out = 8'h45; 8'h6f: out = 8'h06;
		8'h70: out = 8'hd0; 8'h71: out = 8'h2c; 8'h72: out = 8'h1e; 8'h73: out = 8'h8f;
		8'h74: out = 8'hca; 8'h75: out = 8'h3f; 8'h76: out = 8'h0f; 8'h77: out = 8'h02;
		8'h78: out = 8'hc1; 8'h79: out = 8'haf; 8'h7a: out = 8'hbd; 8'h7b: out = 8'h03;
		8'h7c: out = 8'h01; 8'h7d: out = 8'h13; 8'h7e: out = 8'h8a; 8'h7f: out = 8'h6b;
		8'h80: out = 8'h3a; 8'h81: out = 8'h91; 8'h82: out = 8'h11; 8'h83: out = 8'h41;
		8'h84: out = 8'h4f; 8'h85: out = 8'h67; 8'h86: out = 8'hdc; 8'h87: out = 8'hea;
		8'h88: out = 8'h97; 8'h89: out = 8'hf2; 8'h8a: out = 8'hcf; 8'h8b: out = 8'hce;
		8'h8c: out = 8'hf0; 8'h8d: out = 8'hb4; 8'h8e: out = 8'he6; 8'h8f: out = 8'h73;
		8'h90: out = 8'h96; 8'h91: out = 8'hac; 8'h92: out = 8'h74; 8'h93: out = 8'h22;
		8'h94: out = 8'he7; 8'h95: out = 8'had; 8'h96: out = 8'h35; 8'h97: out = 8'h85;
		8'h98: out = 8'he2; 8'h99: out = 8'hf9; 8'h9a: out = 8'h37; 8'h9b: out = 8'he8;
		8'h9c: out = 8'h1c; 8'h9d: out = 8'h75; 8'h9e: out = 8'hdf; 8'h9f: out = 8'h6e;
		8'ha0: out = 8'h47; 8'ha1: out = 8'hf1; 8'ha2: out = 8'h1a; 8'ha3: out = 8'h71;
		8'ha4: out = 8'h1d; 8'ha5: out = 8'h29; 8'ha6: out = 8'hc5; 8'ha7: out = 8'h89;
		8'ha8: out = 8'h6f; 8'ha9: out = 8'hb7; 8'haa: out = 8'h62; 8'hab: out = 8'h0e;
		8'hac: out = 8'haa; 8'had: out = 8'h18; 8'hae: out = 8'hbe; 8'haf: out = 8'h1b;
		8'hb0: out = 8'hfc; 8'hb1: out = 8'h56; 8'hb2: out = 8'h3e; 8'hb3: out = 8'h4b;
		8'hb4: out = 8'hc6; 8'hb5: out = 8'hd2; 8'hb6: out = 8'h79; 8'hb7: out = 8'h20;
		8'hb8: out = 8'h9a; 8'hb9: out = 8'hdb; 8'hba: out = 8'hc0; 8'hbb: out = 8'hfe;
		8'hbc: out = 8'h78; 8'hbd: out = 8'hcd; 8'hbe: out = 8'h5a; 8'hbf: out = 8'hf4;
		8'hc0: out = 8'h1f; 8'hc1: out = 8'hdd; 8'hc2: out = 8'ha8; 8'hc3: out = 8'h33;
		8'hc4: out = 8'h88; 8'hc5: out = 8'h07; 8'hc6: out = 8'hc7; 8'hc7: out = 8'h31;
		8'hc8: out = 8'hb1; 8'hc9: out = 8'h12; 8'hca: out = 8'h10; 8'hcb: out = 8'h59;
		8'hcc: out = 8'h27; 8'hcd: out = 8'h80; 8'hce: out = 8'hec; 8'hcf: out = 8'h5f;
		8'hd0: out = 8'h60; 8'hd1: out = 8'h51; 8'hd2: out = 8'h7f; 8'hd3: out = 8'ha9;
		8'hd4: out = 8'h19; 8'hd5: out = 8'hb5; 8'hd6: out = 8'h4a; 8'hd7: out = 8'h0d;
		8'hd8: out = 8'h2d; 8'hd9: out = 8'he5; 8'hda: out = 8'h7a; 8'hdb: out = 8'h9f;
		8'hdc: out = 8'h93; 8'hdd: out = 8'hc9; 8'hde: out = 8'h9c; 8'hdf: out = 8'hef;
		8'he0: out = 8'ha0; 8'he1: out = 8'he0; 8'he2: out = 8'h3b; 8'he3: out = 8'h4d;
		8'he4: out = 8'hae; 8'he5: out = 8'h2a; 8'he6: out = 8'hf5; 8'he7: out = 8'hb0;
		8'he8: out = 8'hc8; 8'he9: out = 8'heb; 8'hea: out = 8'hbb; 8'heb: out = 8'h3c;
		8'hec: out = 8'h83; 8'hed: out = 8'h53; 8'hee: out = 8'h99; 8'hef: out = 8'h61;
		8'hf0: out = 8'h17; 8'hf1: out = 8'h2b; 8'hf2: out = 8'h04; 8'hf3: out = 8'h7e;
		8'hf4: out = 8'hba; 8'hf5: out = 8'h77; 8'hf6: out = 8'hd6; 8'hf7: out = 8'h26;
		8'hf8: out = 8'he1; 8'hf9: out = 8'h69; 8'hfa: out = 8'h14; 8'hfb: out = 8'h63;
		8'hfc: out = 8'h55; 8'hfd: out = 8'h21; 8'hfe: out = 8'h0c; 8'hff: out = 8'h7d;
		default: out = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/InvMixColumns.sv
`timescale 1ns/1ns
`default_nettype none

module InvMixColumns import AesDecPkg::*; (
	input  wire blockT in,
	output blockT      out
);

	// multiply by x modulo the AES polynomial
	function automatic byteT xtime(input byteT b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	// k selects which of b, 2b, 4b, 8b are summed
	function automatic byteT gfMul(input byteT b, input logic [3:0] k);
		byteT x2;
		byteT x4;
		byteT x8;
		x2 = xtime(b);
		x4 = xtime(x2);
		x8 = xtime(x4);
		return (k[0] ? b : 8'h00) ^ (k[1] ? x2 : 8'h00) ^
			(k[2] ? x4 : 8'h00) ^ (k[3] ? x8 : 8'h00);
	endfunction

	function automatic wordT mixColumn(input wordT col);
		byteT s0;
		byteT s1;
		byteT s2;
		byteT s3;
		s0 = col[31:24];
		s1 = col[23:16];
		s2 = col[15:8];
		s3 = col[7:0];
		mixColumn[31:24] = gfMul(s0, 4'he) ^ gfMul(s1, 4'hb) ^ gfMul(s2, 4'hd) ^ gfMul(s3, 4'h9);
		mixColumn[23:16] = gfMul(s0, 4'h9) ^ gfMul(s1, 4'he) ^ gfMul(s2, 4'hb) ^ gfMul(s3, 4'hd);
		mixColumn[15:8]  = gfMul(s0, 4'hd) ^ gfMul(s1, 4'h9) ^ gfMul(s2, 4'he) ^ gfMul(s3, 4'hb);
		mixColumn[7:0]   = gfMul(s0, 4'hb) ^ gfMul(s1, 4'hd) ^ gfMul(s2, 4'h9) ^ gfMul(s3, 4'he);
	endfunction

	always_comb begin
		for (int c = 0; c < 4; c++) begin
			out[127 - 32 * c -: 32] = mixColumn(in[127 - 32 * c -: 32]); // column c
		end
	end

endmodule

`default_nettype wire

// File: verilog/InvCipherRound.sv
`timescale 1ns/1ns
`default_nettype none

module InvCipherRound import AesDecPkg::*; (
	input  wire blockT state,
	input  wire blockT roundKey,
	input  wire        finalRound,
	output blockT      out
);

	blockT subBytes; // after InvShiftRows and lookups
	blockT keyAdded;
	blockT mixed;

	// byte i holds row i%4 of column i/4
	// InvShiftRows moves row r right by r columns
	for (genvar i = 0; i < 16; i++) begin : gLookup
		localparam int Row = i % 4;
		localparam int Col = i / 4;
		localparam int Src = 4 * ((Col - Row + 4) % 4) + Row; // source byte before the shift

		InvSBoxLookup uSBox (
			.in  (state[127 - 8 * Src -: 8]),
			.out (subBytes[127 - 8 * i -: 8])
		);
	end

	assign keyAdded = subBytes ^ roundKey;

	InvMixColumns uMix (
		.in  (keyAdded),
		.out (mixed)
	);

	assign out = finalRound ? keyAdded : mixed; // last round has no mixing

endmodule

`default_nettype wire

// File: verilog/AesDecSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module AesDecSequencer import AesDecPkg::*; (
	input  wire        clk,
	input  wire        rst,
	input  wire        start,
	input  wire blockT cipherIn,
	input  wire blockT roundKey,
	input  wire blockT roundOut,
	output roundIdxT   keyIdx,
	output blockT      roundIn,
	output logic       finalRound,
	output logic       busy,
	output logic       resultValid,
	output blockT      result
);

	seqStateT seqState;
	blockT    stateReg; // working state between rounds

	always_ff @(posedge clk) begin
		if (rst) begin
			seqState <= SeqIdle;
			keyIdx <= roundIdxT'(NumRounds);
		end else begin
			case (seqState)
			SeqIdle: begin
				if (start) begin
					seqState <= SeqRound;
					keyIdx <= roundIdxT'(NumRounds - 1);
				end
			end
			SeqRound: begin
				if (keyIdx == 4'd0) begin
					seqState <= SeqIdle;
					keyIdx <= roundIdxT'(NumRounds); // park on key 10 for next whitening
				end else begin
					keyIdx <= keyIdx - 4'd1;
				end
			end
			default: seqState <= SeqIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (seqState == SeqIdle && start) begin
			stateReg <= cipherIn ^ roundKey; // initial AddRoundKey with key 10
		end else if (seqState == SeqRound) begin
			stateReg <= roundOut;
		end
	end

	assign roundIn = stateReg;
	assign busy = seqState == SeqRound;
	assign finalRound = keyIdx == 4'd0;
	assign resultValid = busy && finalRound; // last busy cycle
	assign result = roundOut;

	busyLength: assert property (@(posedge clk) disable iff (rst)
		$rose(busy) |-> busy [*NumRounds] ##1 !busy)
		else $error("busy did not last exactly NumRounds cycles");

	noStartWhileBusy: assert property (@(posedge clk) disable iff (rst) busy |-> !start)
		else $error("start seen while busy");

endmodule

`default_nettype wire

// File: verilog/AesDecRegs.sv
`timescale 1ns/1ns
`default_nettype none

module AesDecRegs import AesDecPkg::*; (
	input  wire           clk,
	input  wire           rst,
	input  wire           cyc,
	input  wire           stb,
	input  wire           we,
	input  wire wbAdrT    adr,
	input  wire wordT     datIn,
	output wordT          datOut,
	output logic          ack,
	input  wire roundIdxT keyIdx,
	output blockT         keyOut,
	output blockT         cipherIn,
	output logic          start,
	input  wire           busy,
	input  wire           resultValid,
	input  wire blockT    result
);

	wordT  keyMem [0:4 * (NumRounds + 1) - 1]; // 44 key words
	wordT  inWords [0:3];
	wordT  outWords [0:3];
	logic  served;  // acked, waiting for stb to drop
	logic  newReq;
	logic  wrEn;
	logic  startReq;
	logic  done;
	wbAdrT dataOfs;
	wbAdrT outOfs;
	wbAdrT keyBase;

	assign newReq = cyc && stb && !served;
	assign wrEn = newReq && we && !busy; // writes ignored while running
	assign startReq = wrEn && adr == AdrCtrl && datIn[0];
	assign dataOfs = adr - AdrDataIn;
	assign outOfs = adr - AdrDataOut;

	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
			served <= 1'b0;
		end else begin
			ack <= newReq; // single cycle ack
			if (newReq) begin
				served <= 1'b1;
			end else if (!(cyc && stb)) begin
				served <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			start <= 1'b0;
			done <= 1'b0;
		end else begin
			start <= startReq;
			if (startReq) begin
				done <= 1'b0;
			end else if (resultValid) begin
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wrEn && adr < AdrDataIn) begin
			keyMem[adr - AdrKeyBase] <= datIn;
		end
		if (wrEn && adr >= AdrDataIn && adr < AdrCtrl) begin
			inWords[dataOfs[1:0]] <= datIn;
		end
		if (resultValid) begin
			for (int w = 0; w < 4; w++) begin
				outWords[w] <= result[127 - 32 * w -: 32];
			end
		end
	end

	// read data captured with the request, valid during ack
	always_ff @(posedge clk) begin
		if (newReq) begin
			if (adr < AdrDataIn) begin
				datOut <= keyMem[adr - AdrKeyBase];
			end else if (adr < AdrCtrl) begin
				datOut <= inWords[dataOfs[1:0]];
			end else if (adr == AdrStatus) begin
				datOut <= {30'd0, done, busy};
			end else if (adr >= AdrDataOut && adr < AdrDataOut + 6'd4) begin
				datOut <= outWords[outOfs[1:0]];
			end else begin
				datOut <= '0; // ctrl strobe and unmapped space
			end
		end
	end

	assign keyBase = {keyIdx, 2'b00};
	assign keyOut = {keyMem[keyBase], keyMem[keyBase + 6'd1],
		keyMem[keyBase + 6'd2], keyMem[keyBase + 6'd3]};
	assign cipherIn = {inWords[0], inWords[1], inWords[2], inWords[3]};

	ackSingle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
		else $error("ack held for two cycles");

endmodule

`default_nettype wire

// File: verilog/AesDecTop.sv
`timescale 1ns/1ns
`default_nettype none

module AesDecTop import AesDecPkg::*; (
	input  wire        clk,
	input  wire        rst,
	input  wire        cyc,
	input  wire        stb,
	input  wire        we,
	input  wire wbAdrT adr,
	input  wire wordT  datIn,
	output wire wordT  datOut,
	output wire        ack
);

	wire roundIdxT keyIdx;
	wire blockT    keyOut;
	wire blockT    cipherIn;
	wire blockT    roundIn;
	wire blockT    roundOut;
	wire blockT    result;
	wire           start;
	wire           busy;
	wire           finalRound;
	wire           resultValid;

	AesDecRegs uRegs (
		.clk         (clk),
		.rst         (rst),
		.cyc         (cyc),
		.stb         (stb),
		.we          (we),
		.adr         (adr),
		.datIn       (datIn),
		.datOut      (datOut),
		.ack         (ack),
		.keyIdx      (keyIdx),
		.keyOut      (keyOut),
		.cipherIn    (cipherIn),
		.start       (start),
		.busy        (busy),
		.resultValid (resultValid),
		.result      (result)
	);

	AesDecSequencer uSeq (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.cipherIn    (cipherIn),
		.roundKey    (keyOut),
		.roundOut    (roundOut),
		.keyIdx      (keyIdx),
		.roundIn     (roundIn),
		.finalRound  (finalRound),
		.busy        (busy),
		.resultValid (resultValid),
		.result      (result)
	);

	InvCipherRound uRound (
		.state      (roundIn),
		.roundKey   (keyOut),
		.finalRound (finalRound),
		.out        (roundOut)
	);

endmodule

`default_nettype wire

// File: tb/tbAesModel.svh
`ifndef TB_AES_MODEL_SVH
`define TB_AES_MODEL_SVH

typedef logic [128 * 11 - 1:0] keySetT; // round key r in bits 128*r+127 down to 128*r

byteT sboxTab [0:255]; // forward S-box, filled once at time zero

// carry-less multiply modulo x^8+x^4+x^3+x+1
function automatic byteT gfProduct(input byteT a, input byteT b);
	byteT p;
	byteT x;
	p = 8'h00;
	x = a;
	for (int i = 0; i < 8; i++) begin
		if (b[i]) p = p ^ x;
		x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
	end
	return p;
endfunction

// multiplicative inverse, then the affine map
function automatic byteT sboxByte(input byteT x);
	byteT inv;
	inv = 8'h00; // zero maps to zero
	for (int c = 1; c < 256; c++) begin
		if (gfProduct(x, byteT'(c)) == 8'h01) inv = byteT'(c);
	end
	return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
		{inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

task automatic fillSboxTable();
	for (int i = 0; i < 256; i++) sboxTab[i] = sboxByte(byteT'(i));
endtask

function automatic byteT invSboxByte(input byteT y);
	byteT x;
	x = 8'h00;
	for (int i = 0; i < 256; i++) begin
		if (sboxTab[i] == y) x = byteT'(i);
	end
	return x;
endfunction

function automatic keySetT expandKey(input blockT key);
	wordT   w [0:43];
	wordT   t;
	byteT   rcon;
	keySetT ks;
	rcon = 8'h01;
	for (int i = 0; i < 4; i++) w[i] = key[127 - 32 * i -: 32];
	for (int i = 4; i < 44; i++) begin
		t = w[i - 1];
		if (i % 4 == 0) begin
			t = {sboxTab[t[23:16]], sboxTab[t[15:8]], sboxTab[t[7:0]], sboxTab[t[31:24]]};
			t = t ^ {rcon, 24'h0}; // RotWord and SubWord done above
			rcon = {rcon[6:0], 1'b0} ^ (rcon[7] ? 8'h1b : 8'h00);
		end
		w[i] = w[i - 4] ^ t;
	end
	for (int r = 0; r < 11; r++) begin
		ks[128 * r +: 128] = {w[4 * r], w[4 * r + 1], w[4 * r + 2], w[4 * r + 3]};
	end
	return ks;
endfunction

function automatic blockT invRoundRef(input blockT s, input blockT k, input bit mix);
	blockT       t;
	byteT        a [0:3];
	byteT        m;
	int          src;
	logic [31:0] coefs;
	coefs = 32'h0e0b0d09; // first row of the inverse mixing matrix
	for (int i = 0; i < 16; i++) begin
		src = 4 * ((i / 4 + 4 - i % 4) % 4) + i % 4; // row r came from column c-r
		t[127 - 8 * i -: 8] = invSboxByte(s[127 - 8 * src -: 8]);
	end
	t = t ^ k;
	if (mix) begin
		for (int c = 0; c < 4; c++) begin
			for (int j = 0; j < 4; j++) a[j] = t[127 - 32 * c - 8 * j -: 8];
			for (int r = 0; r < 4; r++) begin
				m = 8'h00;
				for (int j = 0; j < 4; j++) begin
					m = m ^ gfProduct(a[j], coefs[31 - 8 * ((j - r + 4) % 4) -: 8]);
				end
				t[127 - 32 * c - 8 * r -: 8] = m;
			end
		end
	end
	return t;
endfunction

function automatic blockT refDecrypt(input blockT ct, input keySetT ks);
	blockT s;
	s = ct ^ ks[128 * 10 +: 128];
	for (int r = 9; r >= 1; r--) s = invRoundRef(s, ks[128 * r +: 128], 1'b1);
	return invRoundRef(s, ks[127:0], 1'b0); // final round skips mixing
endfunction

`endif

// File: tb/tbAesDecTop.sv
`timescale 1ns/1ns
`default_nettype none

module tbAesDecTop import AesDecPkg::*; ();

	localparam int NumOps = 33;       // FIPS, 30 random, busy writes, unmapped read
	localparam int CyclesPerOp = 200;
	localparam int AckLimit = 16;
	localparam int PollLimit = 50;

	logic      clk;
	logic      rst;
	logic      cyc;
	logic      stb;
	logic      we;
	wbAdrT     adr;
	wordT      datIn;
	wire wordT datOut;
	wire       ack;
	integer    seed;

	// results waiting for the compare process
	blockT expBlocks [$];
	blockT gotBlocks [$];
	int    blockIds [$];
	wordT  expWords [$];
	wordT  gotWords [$];
	wbAdrT wordAdrs [$];

	`include "tbAesModel.svh"

	AesDecTop u_AesDecTop (
		.clk    (clk),
		.rst    (rst),
		.cyc    (cyc),
		.stb    (stb),
		.we     (we),
		.adr    (adr),
		.datIn  (datIn),
		.datOut (datOut),
		.ack    (ack)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TB FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic checkWord(input wbAdrT a, input wordT expected, input wordT got);
		if (got !== expected) begin
			$display("Mismatch at %0t ns: word at address %0d expected %h got %h",
				$time, a, expected, got);
			$display("TB FAILED");
			$fatal(1, "word compare failed");
		end
	endtask

	task automatic checkBlock(input int id, input blockT expected, input blockT got);
		if (got !== expected) begin
			$display("Mismatch at %0t ns: block %0d expected %h got %h", $time, id, expected, got);
			$display("TB FAILED");
			$fatal(1, "block compare failed");
		end
	endtask

	always @(posedge clk) begin
		while (gotWords.size() > 0) begin
			checkWord(wordAdrs.pop_front(), expWords.pop_front(), gotWords.pop_front());
		end
		while (gotBlocks.size() > 0) begin
			checkBlock(blockIds.pop_front(), expBlocks.pop_front(), gotBlocks.pop_front());
		end
	end

	task automatic expectWord(input wbAdrT a, input wordT expected, input wordT got);
		wordAdrs.push_back(a);
		expWords.push_back(expected);
		gotWords.push_back(got);
	endtask

	task automatic expectBlock(input int id, input blockT expected, input blockT got);
		blockIds.push_back(id);
		expBlocks.push_back(expected);
		gotBlocks.push_back(got);
	endtask

	task automatic waitAck(input wbAdrT a);
		int waited;
		waited = 0;
		@(negedge clk);
		while (!ack) begin
			waited++;
			if (waited > AckLimit) abortRun($sformatf("no ack for address %0d", a));
			@(negedge clk);
		end
	endtask

	task automatic wbWrite(input wbAdrT a, input wordT d);
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = a;
		datIn = d;
		waitAck(a);
		cyc = 1'b0; // idle for a cycle before the next request
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic wbRead(input wbAdrT a, output wordT d);
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		adr = a;
		waitAck(a);
		d = datOut;
		cyc = 1'b0;
		stb = 1'b0;
	endtask

	task automatic writeConfig(input keySetT ks, input blockT ct);
		for (int r = 0; r < 11; r++) begin
			for (int w = 0; w < 4; w++) begin
				wbWrite(AdrKeyBase + wbAdrT'(4 * r + w), ks[128 * r + 96 - 32 * w +: 32]);
			end
		end
		for (int w = 0; w < 4; w++) wbWrite(AdrDataIn + wbAdrT'(w), ct[96 - 32 * w +: 32]);
	endtask

	task automatic readBackConfig(input keySetT ks, input blockT ct);
		wordT  d;
		wbAdrT a;
		for (int i = 0; i < 44; i++) begin
			a = AdrKeyBase + wbAdrT'(i);
			wbRead(a, d);
			expectWord(a, ks[128 * (i / 4) + 96 - 32 * (i % 4) +: 32], d);
		end
		for (int w = 0; w < 4; w++) begin
			a = AdrDataIn + wbAdrT'(w);
			wbRead(a, d);
			expectWord(a, ct[96 - 32 * w +: 32], d);
		end
	endtask

	task automatic startEngine();
		wordT st;
		wbWrite(AdrCtrl, 32'h1);
		wbRead(AdrStatus, st);
		expectWord(AdrStatus, 32'h1, st); // busy set, old done cleared
	endtask

	task automatic waitDone();
		wordT st;
		int   polls;
		polls = 0;
		wbRead(AdrStatus, st);
		while (st[0]) begin
			polls++;
			if (polls > PollLimit) abortRun("engine stayed busy, the run hung");
			wbRead(AdrStatus, st);
		end
		expectWord(AdrStatus, 32'h2, st); // done with busy low
	endtask

	task automatic readResult(output blockT pt);
		wordT d;
		for (int w = 0; w < 4; w++) begin
			wbRead(AdrDataOut + wbAdrT'(w), d);
			pt[96 - 32 * w +: 32] = d;
		end
	endtask

	task automatic decryptBlock(input keySetT ks, input blockT ct, output blockT pt);
		writeConfig(ks, ct);
		startEngine();
		waitDone();
		readResult(pt);
	endtask

	task automatic randomKeys(output keySetT ks);
		for (int i = 0; i < 44; i++) ks[32 * i +: 32] = $random(seed);
	endtask

	task automatic randomBlock(output blockT b);
		for (int i = 0; i < 4; i++) b[32 * i +: 32] = $random(seed);
	endtask

	initial begin : stimulus
		keySetT ks;
		blockT  ct;
		blockT  pt;
		wordT   d;
		seed = 32'h70b71463;
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		fillSboxTable();
		repeat (10) @(negedge clk);
		rst = 1'b0;

		// FIPS-197 appendix C.1
		ks = expandKey(128'h000102030405060708090a0b0c0d0e0f);
		ct = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
		decryptBlock(ks, ct, pt);
		expectBlock(0, 128'h00112233445566778899aabbccddeeff, pt);
		readBackConfig(ks, ct);

		for (int i = 1; i <= 30; i++) begin
			randomKeys(ks);
			randomBlock(ct);
			decryptBlock(ks, ct, pt);
			expectBlock(i, refDecrypt(ct, ks), pt);
		end

		// key 1 word 1 and data word 2 rewritten mid-run
		randomKeys(ks);
		randomBlock(ct);
		writeConfig(ks, ct);
		startEngine();
		wbWrite(AdrKeyBase + 6'd5, ~ks[192 +: 32]);
		wbWrite(AdrDataIn + 6'd2, ~ct[32 +: 32]);
		waitDone();
		readResult(pt);
		expectBlock(31, refDecrypt(ct, ks), pt);
		readBackConfig(ks, ct);

		wbRead(6'd60, d); // unmapped
		expectWord(6'd60, 32'h0, d);

		@(posedge clk); // compare process drains the last results here
		@(negedge clk);
		$display("TB PASSED");
		$finish;
	end

	initial begin
		repeat (NumOps * CyclesPerOp) @(posedge clk);
		abortRun("watchdog expired, the run hung");
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+tb
verilog/AesDecPkg.sv
verilog/InvSBoxLookup.sv
verilog/InvMixColumns.sv
verilog/InvCipherRound.sv
verilog/AesDecSequencer.sv
verilog/AesDecRegs.sv
verilog/AesDecTop.sv
tb/tbAesDecTop.sv
